// ==== Makefile ====
# Verilator build, run and lint for the instruction fetch unit

VERILATOR ?= verilator
TOP       ?= tb_ifetch
RTL_TOP   ?= ifetch_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR)

# The log decides the result, the simulator exit code does not
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "Simulation incomplete"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== project.f ====
src/fetch_pkg.sv
src/bus_pkg.sv
src/boot_rom.sv
src/icache_mem.sv
src/icache_ctrl.sv
src/ifetch_top.sv
tests/tb_bus_model.sv
tests/tb_ifetch.sv

// ==== src/boot_rom.sv ====
// ==================================================
// Boot ROM
// Generates a whole line from the read address and
// returns it after ROM_LATENCY register stages
// ==================================================

module boot_rom #(
	parameter int ROM_LATENCY = 2
) (
	input  logic                          clk,
	input  logic                          rd_i,
	input  logic [fetch_pkg::ADR_W-1:0]   adr_i,
	output logic [fetch_pkg::LINE_W-1:0]  line_o
);

	localparam int WORD_W = fetch_pkg::WORD_W;

	logic [fetch_pkg::LINE_W-1:0] gen_line;
	logic [fetch_pkg::LINE_W-1:0] stage_q [ROM_LATENCY];

	// Word k holds the base plus the low 12 bits of its word address
	always_comb begin
		logic [fetch_pkg::ADR_W-3:0] word_adr;
		word_adr = '0;
		for (int k = 0; k < fetch_pkg::LINE_WORDS; k++) begin
			word_adr = adr_i[fetch_pkg::ADR_W-1:2] + (fetch_pkg::ADR_W-2)'(k);
			gen_line[k*WORD_W +: WORD_W] = fetch_pkg::ROM_BASE_WORD + WORD_W'(word_adr[11:0]);
		end
	end

	// Delay chain, the first stage loads only on a read
	always_ff @(posedge clk) begin
		if (rd_i)
			stage_q[0] <= gen_line;
		for (int s = 1; s < ROM_LATENCY; s++)
			stage_q[s] <= stage_q[s-1];
	end

	assign line_o = stage_q[ROM_LATENCY-1];

endmodule

// ==== src/bus_pkg.sv ====
// ==================================================
// Bus and controller package
// Burst cycle-type codes of the external bus and
// the state encoding of the miss controller
// ==================================================

package bus_pkg;

	// Cycle type driven with each burst beat
	typedef enum logic [2:0] {
		CTI_CLASSIC = 3'b000,
		CTI_INCR    = 3'b010,
		CTI_END     = 3'b111
	} cti_e;

	// Miss controller states
	typedef enum logic [2:0] {
		IC_IDLE,
		// Registered cache answer is being checked
		IC_LOOKUP,
		// Counting out the ROM read latency
		IC_ROM_WAIT,
		// Burst in flight, one beat per ack
		IC_BUS_ACK,
		IC_WRITE,
		IC_WAIT_WR
	} ic_state_e;

endpackage

// ==== src/fetch_pkg.sv ====
// ==================================================
// Fetch geometry package
// Address and line sizes, the boot ROM region,
// fault codes and the no-operation fill word
// ==================================================

package fetch_pkg;

	// ==================================================
	// Address and line geometry
	// ==================================================
	localparam int ADR_W      = 32;
	localparam int WORD_W     = 32;
	localparam int LINE_WORDS = 4;
	localparam int LINE_W     = LINE_WORDS * WORD_W;

	// Word written into every slot of a line that took a bus error
	localparam logic [WORD_W-1:0] NOP_INSN = 32'h0000_0013;

	// Fault code stored with each cache line
	typedef enum logic [1:0] {
		FAULT_NONE = 2'b00,
		FAULT_BUS  = 2'b01
	} fault_e;

	// ==================================================
	// Boot ROM region
	// ==================================================
	// Upper address bits that select the ROM instead of the bus
	localparam int               ROM_TAG_W = 20;
	localparam logic [19:0]      ROM_TAG   = 20'hF_FFFF;

	// ROM words are this base plus the low bits of their word address
	localparam logic [WORD_W-1:0] ROM_BASE_WORD = 32'hC0DE_0000;

endpackage

// ==== src/icache_ctrl.sv ====
// ==================================================
// Instruction cache miss controller
// Looks up fetches, fills missing lines from the boot
// ROM or with a four-beat bus burst, writes the line,
// waits out the write latency and returns the word.
// Also services invalidates and counts bus fills
// ==================================================

module icache_ctrl #(
	parameter int LINES       = 16,
	parameter int ROM_LATENCY = 2,
	parameter int WR_LATENCY  = 2
) (
	input  logic                          clk,
	input  logic                          rst_i,
	// Fetch side
	input  logic                          fetch_i,
	input  logic [fetch_pkg::ADR_W-1:0]   fetch_adr_i,
	input  logic                          inv_i,
	input  logic [fetch_pkg::ADR_W-1:0]   inv_adr_i,
	// Cache lookup
	output logic                          lookup_o,
	output logic [fetch_pkg::ADR_W-1:0]   lookup_adr_o,
	input  logic                          hit_i,
	input  logic                          hit_fault_i,
	input  logic [fetch_pkg::LINE_W-1:0]  line_i,
	// Line write and invalidate
	output logic                          line_wr_o,
	output logic                          line_inv_o,
	output logic [fetch_pkg::ADR_W-1:0]   line_adr_o,
	output logic [fetch_pkg::LINE_W-1:0]  line_dat_o,
	output fetch_pkg::fault_e             line_fault_o,
	// Boot ROM
	output logic                          rom_rd_o,
	output logic [fetch_pkg::ADR_W-1:0]   rom_adr_o,
	input  logic [fetch_pkg::LINE_W-1:0]  rom_line_i,
	// External bus
	output logic                          cyc_o,
	output logic                          stb_o,
	output bus_pkg::cti_e                 cti_o,
	output logic [fetch_pkg::ADR_W-1:0]   adr_o,
	input  logic                          ack_i,
	input  logic                          err_i,
	input  logic [fetch_pkg::WORD_W-1:0]  dat_i,
	// Result
	output logic [fetch_pkg::WORD_W-1:0]  insn_o,
	output logic                          insn_valid_o,
	output logic                          fault_o,
	output logic [31:0]                   fill_count_o
);

	localparam int ADR_W  = fetch_pkg::ADR_W;
	localparam int WORD_W = fetch_pkg::WORD_W;
	localparam int WSEL_W = $clog2(fetch_pkg::LINE_WORDS);
	localparam int OFS_W  = WSEL_W + 2;
	localparam int IDX_W  = $clog2(LINES);

	bus_pkg::ic_state_e  state;
	logic [ADR_W-1:0]    req_adr;
	logic [ADR_W-1:0]    req_line_adr;
	logic [ADR_W-1:0]    fetch_adr_r;
	logic [ADR_W-1:0]    fetch_adr_sel;
	logic [ADR_W-1:0]    inv_adr_r;
	logic                fetch_pend;
	logic                fetch_req;
	logic                fetch_blocked;
	logic                inv_pend;
	logic [WSEL_W-1:0]   req_word;
	logic [WSEL_W-1:0]   beat;
	logic                req_is_rom;
	logic [7:0]          wait_cnt;

	// True when two addresses map onto the same cache line slot
	function automatic logic same_idx(input logic [ADR_W-1:0] a, input logic [ADR_W-1:0] b);
		return a[OFS_W +: IDX_W] == b[OFS_W +: IDX_W];
	endfunction

	// ==================================================
	// Request selection
	// ==================================================
	assign fetch_req     = fetch_i | fetch_pend;
	assign fetch_adr_sel = fetch_pend ? fetch_adr_r : fetch_adr_i;

	// Invalidate wins over a fetch to the same slot
	// Such a fetch waits in the pending register
	// A fetch to a different slot cannot see the invalidate and goes ahead
	assign fetch_blocked = (inv_pend && same_idx(inv_adr_r, fetch_adr_sel)) ||
		(inv_i && same_idx(inv_adr_i, fetch_adr_sel));

	assign lookup_o     = (state == bus_pkg::IC_IDLE) && fetch_req && !fetch_blocked;
	assign lookup_adr_o = fetch_adr_sel;

	// Latched invalidate only goes out while idle
	assign line_inv_o   = (state == bus_pkg::IC_IDLE) && inv_pend;

	assign req_line_adr = {req_adr[ADR_W-1:OFS_W], {OFS_W{1'b0}}};
	assign req_word     = req_adr[2 +: WSEL_W];
	assign req_is_rom   = req_adr[ADR_W-1 -: fetch_pkg::ROM_TAG_W] == fetch_pkg::ROM_TAG;
	assign rom_adr_o    = req_line_adr;
	assign line_adr_o   = line_inv_o ? {inv_adr_r[ADR_W-1:OFS_W], {OFS_W{1'b0}}} : req_line_adr;

	// ==================================================
	// Controller FSM
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			state        <= bus_pkg::IC_IDLE;
			fetch_pend   <= 1'b0;
			inv_pend     <= 1'b0;
			insn_valid_o <= 1'b0;
			line_wr_o    <= 1'b0;
			rom_rd_o     <= 1'b0;
			cyc_o        <= 1'b0;
			stb_o        <= 1'b0;
			cti_o        <= bus_pkg::CTI_CLASSIC;
			fill_count_o <= '0;
			wait_cnt     <= '0;
			beat         <= '0;
		end else begin
			// Strobes last one cycle
			insn_valid_o <= 1'b0;
			line_wr_o    <= 1'b0;
			rom_rd_o     <= 1'b0;

			// One invalidate slot
			// A newer strobe replaces an unserviced one
			if (line_inv_o)
				inv_pend <= 1'b0;
			if (inv_i) begin
				inv_pend  <= 1'b1;
				inv_adr_r <= inv_adr_i;
			end

			// Hold a fetch that could not be looked up this cycle
			if (lookup_o) begin
				fetch_pend <= 1'b0;
			end else if (fetch_i) begin
				fetch_pend  <= 1'b1;
				fetch_adr_r <= fetch_adr_i;
			end

			case (state)
			bus_pkg::IC_IDLE: begin
				if (lookup_o) begin
					req_adr <= fetch_adr_sel;
					state   <= bus_pkg::IC_LOOKUP;
				end
			end
			bus_pkg::IC_LOOKUP: begin
				if (hit_i) begin
					insn_o       <= line_i[req_word*WORD_W +: WORD_W];
					fault_o      <= hit_fault_i;
					insn_valid_o <= 1'b1;
					state        <= bus_pkg::IC_IDLE;
				end else if (req_is_rom) begin
					// ROM region needs no bus cycle and no fill count
					rom_rd_o     <= 1'b1;
					wait_cnt     <= '0;
					line_fault_o <= fetch_pkg::FAULT_NONE;
					state        <= bus_pkg::IC_ROM_WAIT;
				end else begin
					// Start the burst at the line base
					cyc_o        <= 1'b1;
					stb_o        <= 1'b1;
					cti_o        <= bus_pkg::CTI_INCR;
					adr_o        <= req_line_adr;
					beat         <= '0;
					line_fault_o <= fetch_pkg::FAULT_NONE;
					state        <= bus_pkg::IC_BUS_ACK;
				end
			end
			bus_pkg::IC_ROM_WAIT: begin
				// ROM line is valid exactly ROM_LATENCY cycles after the read strobe
				if (wait_cnt == 8'(ROM_LATENCY)) begin
					line_dat_o <= rom_line_i;
					line_wr_o  <= 1'b1;
					state      <= bus_pkg::IC_WRITE;
				end else begin
					wait_cnt <= wait_cnt + 8'd1;
				end
			end
			bus_pkg::IC_BUS_ACK: begin
				if (err_i) begin
					// First error ends the burst
					// The whole line becomes a faulted NOP line
					line_dat_o   <= {fetch_pkg::LINE_WORDS{fetch_pkg::NOP_INSN}};
					line_fault_o <= fetch_pkg::FAULT_BUS;
					cyc_o        <= 1'b0;
					stb_o        <= 1'b0;
					cti_o        <= bus_pkg::CTI_CLASSIC;
					fill_count_o <= fill_count_o + 32'd1;
					line_wr_o    <= 1'b1;
					state        <= bus_pkg::IC_WRITE;
				end else if (ack_i) begin
					line_dat_o[beat*WORD_W +: WORD_W] <= dat_i;
					beat  <= beat + WSEL_W'(1);
					adr_o <= adr_o + 32'd4;
					// Mark the coming beat as the last one
					if (beat == WSEL_W'(fetch_pkg::LINE_WORDS - 2))
						cti_o <= bus_pkg::CTI_END;
					if (beat == WSEL_W'(fetch_pkg::LINE_WORDS - 1)) begin
						cyc_o        <= 1'b0;
						stb_o        <= 1'b0;
						cti_o        <= bus_pkg::CTI_CLASSIC;
						fill_count_o <= fill_count_o + 32'd1;
						line_wr_o    <= 1'b1;
						state        <= bus_pkg::IC_WRITE;
					end
				end
			end
			bus_pkg::IC_WRITE: begin
				// line_wr_o is high in this cycle
				if (WR_LATENCY <= 1) begin
					insn_o       <= line_dat_o[req_word*WORD_W +: WORD_W];
					fault_o      <= line_fault_o != fetch_pkg::FAULT_NONE;
					insn_valid_o <= 1'b1;
					state        <= bus_pkg::IC_IDLE;
				end else begin
					wait_cnt <= 8'd1;
					state    <= bus_pkg::IC_WAIT_WR;
				end
			end
			bus_pkg::IC_WAIT_WR: begin
				// Word goes out WR_LATENCY cycles after the line write
				if (wait_cnt >= 8'(WR_LATENCY - 1)) begin
					insn_o       <= line_dat_o[req_word*WORD_W +: WORD_W];
					fault_o      <= line_fault_o != fetch_pkg::FAULT_NONE;
					insn_valid_o <= 1'b1;
					state        <= bus_pkg::IC_IDLE;
				end else begin
					wait_cnt <= wait_cnt + 8'd1;
				end
			end
			default: begin
				state <= bus_pkg::IC_IDLE;
			end
			endcase
		end
	end

endmodule

// ==== src/icache_mem.sv ====
// ==================================================
// L1 instruction cache arrays
// Direct-mapped tag, valid, fault and data storage
// with a registered lookup and line write/invalidate
// ==================================================

module icache_mem #(
	parameter int LINES = 16
) (
	input  logic                          clk,
	input  logic                          rst_i,
	// Lookup, answered one cycle later
	input  logic                          lookup_i,
	input  logic [fetch_pkg::ADR_W-1:0]   lookup_adr_i,
	output logic                          hit_o,
	output logic                          hit_fault_o,
	output logic [fetch_pkg::LINE_W-1:0]  line_o,
	// Line write and invalidate
	input  logic                          wr_i,
	input  logic                          inv_i,
	input  logic [fetch_pkg::ADR_W-1:0]   line_adr_i,
	input  logic [fetch_pkg::LINE_W-1:0]  line_dat_i,
	input  fetch_pkg::fault_e             line_fault_i
);

	localparam int ADR_W = fetch_pkg::ADR_W;
	localparam int OFS_W = $clog2(fetch_pkg::LINE_WORDS) + 2;
	localparam int IDX_W = $clog2(LINES);
	localparam int TAG_W = ADR_W - IDX_W - OFS_W;

	logic [TAG_W-1:0]             tag_mem   [LINES];
	fetch_pkg::fault_e            fault_mem [LINES];
	logic [fetch_pkg::LINE_W-1:0] data_mem  [LINES];
	logic [LINES-1:0]             valid_q;

	logic [IDX_W-1:0] rd_idx;
	logic [TAG_W-1:0] rd_tag;
	logic [IDX_W-1:0] wr_idx;
	logic [TAG_W-1:0] wr_tag;

	// Split addresses into tag and index
	assign rd_idx = lookup_adr_i[OFS_W +: IDX_W];
	assign rd_tag = lookup_adr_i[ADR_W-1 -: TAG_W];
	assign wr_idx = line_adr_i[OFS_W +: IDX_W];
	assign wr_tag = line_adr_i[ADR_W-1 -: TAG_W];

	// ==================================================
	// Valid bits
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= '0;
		end else begin
			if (wr_i)
				valid_q[wr_idx] <= 1'b1;
			// Invalidate drops the slot whatever tag it holds
			if (inv_i)
				valid_q[wr_idx] <= 1'b0;
		end
	end

	// Tag, fault and data arrays
	always_ff @(posedge clk) begin
		if (wr_i) begin
			tag_mem[wr_idx]   <= wr_tag;
			fault_mem[wr_idx] <= line_fault_i;
			data_mem[wr_idx]  <= line_dat_i;
		end
	end

	// ==================================================
	// Registered lookup
	// ==================================================
	// Reads the arrays before a same-cycle write lands
	always_ff @(posedge clk) begin
		if (rst_i)
			hit_o <= 1'b0;
		else
			hit_o <= lookup_i && valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
	end

	always_ff @(posedge clk) begin
		if (lookup_i) begin
			hit_fault_o <= fault_mem[rd_idx] != fetch_pkg::FAULT_NONE;
			line_o      <= data_mem[rd_idx];
		end
	end

endmodule

// ==== src/ifetch_top.sv ====
// ==================================================
// Instruction fetch unit top level
// Miss controller, direct-mapped L1 arrays and boot
// ROM, with a four-beat burst port to the bus
// ==================================================

module ifetch_top #(
	parameter int LINES       = 16,
	parameter int ROM_LATENCY = 2,
	parameter int WR_LATENCY  = 2
) (
	input  logic                          clk,
	input  logic                          rst_i,
	// Fetch request
	input  logic                          fetch_i,
	input  logic [fetch_pkg::ADR_W-1:0]   fetch_adr_i,
	input  logic                          inv_i,
	input  logic [fetch_pkg::ADR_W-1:0]   inv_adr_i,
	// Fetch result
	output logic [fetch_pkg::WORD_W-1:0]  insn_o,
	output logic                          insn_valid_o,
	output logic                          fault_o,
	output logic [31:0]                   fill_count_o,
	// External bus
	output logic                          cyc_o,
	output logic                          stb_o,
	output bus_pkg::cti_e                 cti_o,
	output logic [fetch_pkg::ADR_W-1:0]   adr_o,
	input  logic                          ack_i,
	input  logic                          err_i,
	input  logic [fetch_pkg::WORD_W-1:0]  dat_i
);

	// Controller to cache
	logic                         lookup;
	logic [fetch_pkg::ADR_W-1:0]  lookup_adr;
	logic                         hit;
	logic                         hit_fault;
	logic [fetch_pkg::LINE_W-1:0] cache_line;
	logic                         line_wr;
	logic                         line_inv;
	logic [fetch_pkg::ADR_W-1:0]  line_adr;
	logic [fetch_pkg::LINE_W-1:0] line_dat;
	fetch_pkg::fault_e            line_fault;
	// Controller to ROM
	logic                         rom_rd;
	logic [fetch_pkg::ADR_W-1:0]  rom_adr;
	logic [fetch_pkg::LINE_W-1:0] rom_line;

	icache_ctrl #(
		.LINES       (LINES),
		.ROM_LATENCY (ROM_LATENCY),
		.WR_LATENCY  (WR_LATENCY)
	) u_ctrl (
		.clk          (clk),
		.rst_i        (rst_i),
		.fetch_i      (fetch_i),
		.fetch_adr_i  (fetch_adr_i),
		.inv_i        (inv_i),
		.inv_adr_i    (inv_adr_i),
		.lookup_o     (lookup),
		.lookup_adr_o (lookup_adr),
		.hit_i        (hit),
		.hit_fault_i  (hit_fault),
		.line_i       (cache_line),
		.line_wr_o    (line_wr),
		.line_inv_o   (line_inv),
		.line_adr_o   (line_adr),
		.line_dat_o   (line_dat),
		.line_fault_o (line_fault),
		.rom_rd_o     (rom_rd),
		.rom_adr_o    (rom_adr),
		.rom_line_i   (rom_line),
		.cyc_o        (cyc_o),
		.stb_o        (stb_o),
		.cti_o        (cti_o),
		.adr_o        (adr_o),
		.ack_i        (ack_i),
		.err_i        (err_i),
		.dat_i        (dat_i),
		.insn_o       (insn_o),
		.insn_valid_o (insn_valid_o),
		.fault_o      (fault_o),
		.fill_count_o (fill_count_o)
	);

	icache_mem #(
		.LINES (LINES)
	) u_mem (
		.clk          (clk),
		.rst_i        (rst_i),
		.lookup_i     (lookup),
		.lookup_adr_i (lookup_adr),
		.hit_o        (hit),
		.hit_fault_o  (hit_fault),
		.line_o       (cache_line),
		.wr_i         (line_wr),
		.inv_i        (line_inv),
		.line_adr_i   (line_adr),
		.line_dat_i   (line_dat),
		.line_fault_i (line_fault)
	);

	boot_rom #(
		.ROM_LATENCY (ROM_LATENCY)
	) u_rom (
		.clk    (clk),
		.rd_i   (rom_rd),
		.adr_i  (rom_adr),
		.line_o (rom_line)
	);

endmodule

// ==== tests/tb_bus_model.sv ====
// ==================================================
// Bus slave model
// Answers bursts with random wait states, raises err
// in one address window, counts bursts and reports
// each beat with its expected address and cycle type
// ==================================================

module tb_bus_model (
	input  logic        clk,
	input  logic        rst_i,
	input  logic        cyc_i,
	input  logic        stb_i,
	input  logic [2:0]  cti_i,
	input  logic [31:0] adr_i,
	output logic        ack_o,
	output logic        err_o,
	output logic [31:0] dat_o,
	output logic [31:0] burst_count_o,
	// One pulse per beat start
	output logic        beat_o,
	output logic [31:0] beat_adr_o,
	output logic [2:0]  beat_cti_o,
	output logic [31:0] exp_adr_o,
	output logic [2:0]  exp_cti_o
);
	timeunit 1ns;
	timeprecision 100ps;

	logic        cyc_q;
	logic        in_beat;
	logic [31:0] base_adr;
	int unsigned wait_left;
	int unsigned beat_idx;

	// Memory content, address rotated left by 7 then XOR pattern
	function automatic logic [31:0] bus_word(input logic [31:0] a);
		return {a[24:0], a[31:25]} ^ 32'h5A5A_5A5A;
	endfunction

	initial begin
		ack_o         = 1'b0;
		err_o         = 1'b0;
		dat_o         = '0;
		burst_count_o = '0;
		beat_o        = 1'b0;
		beat_adr_o    = '0;
		beat_cti_o    = '0;
		exp_adr_o     = '0;
		exp_cti_o     = '0;
		cyc_q         = 1'b0;
		in_beat       = 1'b0;
		base_adr      = '0;
		wait_left     = 0;
		beat_idx      = 0;
		forever begin
			@(posedge clk);
			#1;
			ack_o  = 1'b0;
			err_o  = 1'b0;
			beat_o = 1'b0;
			if (rst_i) begin
				cyc_q         = 1'b0;
				in_beat       = 1'b0;
				burst_count_o = '0;
			end else begin
				// A rising cyc opens a new burst at the line base
				if (cyc_i && !cyc_q) begin
					burst_count_o = burst_count_o + 32'd1;
					base_adr      = {adr_i[31:4], 4'h0};
					beat_idx      = 0;
				end
				cyc_q = cyc_i;
				if (cyc_i && stb_i) begin
					if (!in_beat) begin
						in_beat    = 1'b1;
						wait_left  = $urandom_range(0, 3);
						beat_o     = 1'b1;
						beat_adr_o = adr_i;
						beat_cti_o = cti_i;
						exp_adr_o  = base_adr + 32'(beat_idx * 4);
						// Last beat of four is marked as end of burst
						exp_cti_o  = (beat_idx == 3) ? bus_pkg::CTI_END : bus_pkg::CTI_INCR;
					end
					if (wait_left == 0) begin
						in_beat  = 1'b0;
						beat_idx = beat_idx + 1;
						// Error window
						if (adr_i >= 32'h0000_8000 && adr_i <= 32'h0000_80FF) begin
							err_o = 1'b1;
						end else begin
							ack_o = 1'b1;
							dat_o = bus_word(adr_i);
						end
					end else begin
						wait_left = wait_left - 1;
					end
				end
			end
		end
	end

endmodule

// ==== tests/tb_ifetch.sv ====
// ==================================================
// Instruction fetch unit testbench
// Drives fetches and invalidates, models the cache
// tags to predict hits and fills, checks every word
// ==================================================

module tb_ifetch;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int LINES       = 16;
	localparam int ROM_LATENCY = 2;
	localparam int WR_LATENCY  = 2;
	localparam int IDX_W       = $clog2(LINES);
	localparam int NUM_RANDOM  = 40;
	// Random fetches plus the directed ones below
	localparam int NUM_FETCHES = NUM_RANDOM + 10;
	localparam int CYCLE_LIMIT = NUM_FETCHES * 60;

	logic        clk;
	logic        rst_i;
	logic        fetch_i;
	logic [31:0] fetch_adr_i;
	logic        inv_i;
	logic [31:0] inv_adr_i;
	logic [31:0] insn_o;
	logic        insn_valid_o;
	logic        fault_o;
	logic [31:0] fill_count_o;
	logic        cyc_o;
	logic        stb_o;
	bus_pkg::cti_e cti_o;
	logic [31:0] adr_o;
	logic        ack_i;
	logic        err_i;
	logic [31:0] dat_i;
	logic [31:0] burst_count;
	logic        beat;
	logic [31:0] beat_adr;
	logic [2:0]  beat_cti;
	logic [31:0] exp_adr;
	logic [2:0]  exp_cti;

	// Tag model, whole line address per slot
	logic [27:0] model_line  [LINES];
	logic        model_valid [LINES];
	// Expected responses in fetch order
	logic [31:0] exp_word_q  [$];
	logic        exp_fault_q [$];
	int          exp_lat_q   [$];
	int          issue_q     [$];
	int          exp_fill_q  [$];
	int          exp_burst_q [$];

	int cycle       = 0;
	int issued      = 0;
	int resp_count  = 0;
	int fills_exp   = 0;
	int bursts_exp  = 0;
	int check_count = 0;
	int error_count = 0;

	ifetch_top #(
		.LINES       (LINES),
		.ROM_LATENCY (ROM_LATENCY),
		.WR_LATENCY  (WR_LATENCY)
	) dut (
		.clk          (clk),
		.rst_i        (rst_i),
		.fetch_i      (fetch_i),
		.fetch_adr_i  (fetch_adr_i),
		.inv_i        (inv_i),
		.inv_adr_i    (inv_adr_i),
		.insn_o       (insn_o),
		.insn_valid_o (insn_valid_o),
		.fault_o      (fault_o),
		.fill_count_o (fill_count_o),
		.cyc_o        (cyc_o),
		.stb_o        (stb_o),
		.cti_o        (cti_o),
		.adr_o        (adr_o),
		.ack_i        (ack_i),
		.err_i        (err_i),
		.dat_i        (dat_i)
	);

	tb_bus_model bus (
		.clk           (clk),
		.rst_i         (rst_i),
		.cyc_i         (cyc_o),
		.stb_i         (stb_o),
		.cti_i         (cti_o),
		.adr_i         (adr_o),
		.ack_o         (ack_i),
		.err_o         (err_i),
		.dat_o         (dat_i),
		.burst_count_o (burst_count),
		.beat_o        (beat),
		.beat_adr_o    (beat_adr),
		.beat_cti_o    (beat_cti),
		.exp_adr_o     (exp_adr),
		.exp_cti_o     (exp_cti)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	// Expected {fault, word} for a fetch address
	function automatic logic [32:0] expected_word(input logic [31:0] adr);
		logic [29:0] wadr;
		wadr = adr[31:2];
		// ROM region, base plus low 12 bits of the word address
		if (adr[31:12] == 20'hF_FFFF)
			return {1'b0, 32'hC0DE_0000 + {20'h0, wadr[11:0]}};
		if (adr >= 32'h0000_8000 && adr <= 32'h0000_80FF)
			return {1'b1, fetch_pkg::NOP_INSN};
		return {1'b0, {adr[24:0], adr[31:25]} ^ 32'h5A5A_5A5A};
	endfunction

	// ==================================================
	// Stimulus tasks
	// ==================================================
	task automatic do_fetch(input logic [31:0] adr);
		int          idx;
		logic        hit;
		logic        rom;
		logic [32:0] ref_val;
		idx     = int'(adr[4 +: IDX_W]);
		hit     = model_valid[idx] && (model_line[idx] == adr[31:4]);
		rom     = adr[31:12] == 20'hF_FFFF;
		ref_val = expected_word(adr);
		// Only bus misses start a burst and count as a fill
		if (!hit && !rom) begin
			fills_exp++;
			bursts_exp++;
		end
		model_valid[idx] = 1'b1;
		model_line[idx]  = adr[31:4];
		exp_word_q.push_back(ref_val[31:0]);
		exp_fault_q.push_back(ref_val[32]);
		// Bus miss latency depends on wait states, left unchecked
		exp_lat_q.push_back(hit ? 2 : (rom ? 2 + ROM_LATENCY + 1 + WR_LATENCY : 0));
		exp_fill_q.push_back(fills_exp);
		exp_burst_q.push_back(bursts_exp);
		@(posedge clk);
		#10;
		fetch_i     = 1'b1;
		fetch_adr_i = adr;
		issue_q.push_back(cycle);
		issued++;
		@(posedge clk);
		#10;
		fetch_i = 1'b0;
		while (resp_count < issued)
			@(posedge clk);
	endtask

	task automatic do_invalidate(input logic [31:0] adr);
		@(posedge clk);
		#10;
		inv_i     = 1'b1;
		inv_adr_i = adr;
		@(posedge clk);
		#10;
		inv_i = 1'b0;
		// Latch, then the strobe to the arrays while idle
		repeat (2) @(posedge clk);
		model_valid[int'(adr[4 +: IDX_W])] = 1'b0;
	endtask

	// ==================================================
	// Monitors and timeout
	// ==================================================
	always @(negedge clk) begin
		if (insn_valid_o) begin
			if (exp_word_q.size() == 0) begin
				error_count++;
				$display("insn_valid_o came with no fetch outstanding");
			end else begin
				check_value("insn_o", insn_o, exp_word_q.pop_front());
				check_value("fault_o", 32'(fault_o), 32'(exp_fault_q.pop_front()));
				check_value("fill_count_o", fill_count_o, exp_fill_q.pop_front());
				check_value("burst count", burst_count, exp_burst_q.pop_front());
				if (exp_lat_q[0] != 0)
					check_value("fetch latency", cycle - issue_q[0], exp_lat_q[0]);
				void'(exp_lat_q.pop_front());
				void'(issue_q.pop_front());
				resp_count++;
			end
		end
		// Beat order and cycle type as seen by the bus model
		if (beat) begin
			check_value("adr_o", beat_adr, exp_adr);
			check_value("cti_o", 32'(beat_cti), 32'(exp_cti));
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle > CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles with %0d of %0d fetches answered",
				cycle, resp_count, issued);
			$display("Testbench failed");
			$finish;
		end
	end

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin
		logic [31:0] adr;
		void'($urandom(22521));
		rst_i       = 1'b1;
		fetch_i     = 1'b0;
		fetch_adr_i = '0;
		inv_i       = 1'b0;
		inv_adr_i   = '0;
		for (int i = 0; i < LINES; i++)
			model_valid[i] = 1'b0;
		repeat (2) @(posedge clk);
		#10;
		rst_i = 1'b0;
		check_value("insn_valid_o", 32'(insn_valid_o), 32'd0);
		check_value("cyc_o", 32'(cyc_o), 32'd0);
		check_value("stb_o", 32'(stb_o), 32'd0);
		check_value("cti_o", 32'(cti_o), 32'(bus_pkg::CTI_CLASSIC));
		check_value("fill_count_o", fill_count_o, 32'd0);
		// Random fetches over 32 lines, so slots get reused and evicted
		for (int i = 0; i < NUM_RANDOM; i++) begin
			adr = 32'h0001_0000 + ($urandom_range(0, 127) << 2);
			do_fetch(adr);
		end
		// Miss then hit in the same line
		do_fetch(32'h0002_0040);
		do_fetch(32'h0002_0048);
		// ROM region, no bus traffic
		do_fetch(32'hFFFF_F000);
		do_fetch(32'hFFFF_F00C);
		do_fetch(32'hFFFF_F7F4);
		// Error window, faulted line stays cached
		do_fetch(32'h0000_8010);
		do_fetch(32'h0000_8014);
		// Invalidate forces exactly one new burst
		do_fetch(32'h0003_0020);
		do_fetch(32'h0003_0024);
		do_invalidate(32'h0003_0020);
		do_fetch(32'h0003_0028);
		repeat (4) @(posedge clk);
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule
